// File: hdl/cpu_pkg.sv
package cpu_pkg;

  //////////////////////////////
  // widths
  //////////////////////////////

  localparam int word_width     = 32;
  localparam int instr_width    = 32;
  localparam int reg_addr_width = 5;
  localparam int shamt_width    = 5;
  localparam int imm_width      = 16;
  localparam int opcode_width   = 6;
  localparam int alu_op_width   = 4;

  localparam int num_regs = 32;

  //////////////////////////////
  // instruction field positions
  //////////////////////////////

  localparam int opcode_msb = 31;
  localparam int opcode_lsb = 26;
  localparam int rs_msb     = 25;
  localparam int rs_lsb     = 21;
  localparam int rt_msb     = 20;
  localparam int rt_lsb     = 16;
  localparam int rd_msb     = 15;
  localparam int rd_lsb     = 11;
  localparam int shamt_msb  = 10;
  localparam int shamt_lsb  = 6;
  localparam int imm_msb    = 15;
  localparam int imm_lsb    = 0;

  typedef logic [word_width-1:0]     word_t;
  typedef logic [instr_width-1:0]    instr_t;
  typedef logic [reg_addr_width-1:0] reg_addr_t;
  typedef logic [shamt_width-1:0]    shamt_t;
  typedef logic [imm_width-1:0]      imm_t;

  // unlisted encodings decode as nop
  typedef enum logic [opcode_width-1:0] {
    op_nop  = 6'd0,
    op_add  = 6'd1,
    op_sub  = 6'd2,
    op_and  = 6'd3,
    op_or   = 6'd4,
    op_xor  = 6'd5,
    op_slt  = 6'd6,
    op_sll  = 6'd7,
    op_srl  = 6'd8,
    op_addi = 6'd9,
    op_andi = 6'd10,
    op_ori  = 6'd11,
    op_lui  = 6'd12
  } opcode_t;

  typedef enum logic [alu_op_width-1:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt,
    alu_sll,
    alu_srl,
    alu_lui
  } alu_op_t;

endpackage

// File: hdl/register_file.sv
`timescale 1ns/1ns

module register_file (
  input  logic               clk,
  input  logic               rst,
  input  cpu_pkg::reg_addr_t rd_addr_a,
  input  cpu_pkg::reg_addr_t rd_addr_b,
  output cpu_pkg::word_t     rd_data_a,
  output cpu_pkg::word_t     rd_data_b,
  input  logic               wr_en,
  input  cpu_pkg::reg_addr_t wr_addr,
  input  cpu_pkg::word_t     wr_data
);

  cpu_pkg::word_t regs [cpu_pkg::num_regs];

  // r0 hardwired, same-cycle write passes straight through
  function automatic cpu_pkg::word_t read_port(cpu_pkg::reg_addr_t addr);
    if (addr == '0) begin
      return '0;
    end
    if (wr_en && wr_addr == addr) begin
      return wr_data;
    end
    return regs[addr];
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < cpu_pkg::num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr_addr] <= wr_data;
    end
  end

  always_comb begin
    rd_data_a = read_port(rd_addr_a);
    rd_data_b = read_port(rd_addr_b);
  end

  // decode drops r0 destinations, so none reach the write port
  a_no_r0_write: assert property (@(posedge clk) disable iff (rst)
    !(wr_en && wr_addr == '0));

endmodule

// File: hdl/decode_stage.sv
`timescale 1ns/1ns

module decode_stage (
  input  logic                clk,
  input  logic                rst,
  input  logic                instr_valid,
  input  cpu_pkg::instr_t     instr,
  input  cpu_pkg::word_t      rd_data_a,
  input  cpu_pkg::word_t      rd_data_b,
  output cpu_pkg::reg_addr_t  rd_addr_a,
  output cpu_pkg::reg_addr_t  rd_addr_b,
  output logic                ex_valid,
  output logic                ex_write,
  output cpu_pkg::alu_op_t    ex_alu_op,
  output cpu_pkg::reg_addr_t  ex_dest,
  output cpu_pkg::reg_addr_t  ex_rs,
  output cpu_pkg::reg_addr_t  ex_rt,
  output cpu_pkg::word_t      ex_a,
  output cpu_pkg::word_t      ex_b,
  output logic                ex_use_imm,
  output cpu_pkg::imm_t       ex_imm,
  output cpu_pkg::shamt_t     ex_shamt
);

  //////////////////////////////
  // field split
  //////////////////////////////

  cpu_pkg::opcode_t   opcode;
  cpu_pkg::reg_addr_t rs;
  cpu_pkg::reg_addr_t rt;
  cpu_pkg::reg_addr_t rd;
  cpu_pkg::shamt_t    shamt;
  cpu_pkg::imm_t      imm;

  assign opcode = cpu_pkg::opcode_t'(instr[cpu_pkg::opcode_msb:cpu_pkg::opcode_lsb]);
  assign rs     = instr[cpu_pkg::rs_msb:cpu_pkg::rs_lsb];
  assign rt     = instr[cpu_pkg::rt_msb:cpu_pkg::rt_lsb];
  assign rd     = instr[cpu_pkg::rd_msb:cpu_pkg::rd_lsb];
  assign shamt  = instr[cpu_pkg::shamt_msb:cpu_pkg::shamt_lsb];
  assign imm    = instr[cpu_pkg::imm_msb:cpu_pkg::imm_lsb];

  assign rd_addr_a = rs;
  assign rd_addr_b = rt;

  //////////////////////////////
  // control decode
  //////////////////////////////

  cpu_pkg::alu_op_t   alu_op;
  cpu_pkg::reg_addr_t dest;
  logic               writes;
  logic               use_imm;

  always_comb begin
    alu_op  = cpu_pkg::alu_add;
    dest    = rd;
    writes  = 1'b1;
    use_imm = 1'b0;
    case (opcode)
      cpu_pkg::op_add:  alu_op = cpu_pkg::alu_add;
      cpu_pkg::op_sub:  alu_op = cpu_pkg::alu_sub;
      cpu_pkg::op_and:  alu_op = cpu_pkg::alu_and;
      cpu_pkg::op_or:   alu_op = cpu_pkg::alu_or;
      cpu_pkg::op_xor:  alu_op = cpu_pkg::alu_xor;
      cpu_pkg::op_slt:  alu_op = cpu_pkg::alu_slt;
      cpu_pkg::op_sll:  alu_op = cpu_pkg::alu_sll;
      cpu_pkg::op_srl:  alu_op = cpu_pkg::alu_srl;
      // i-type ops target rt
      cpu_pkg::op_addi, cpu_pkg::op_andi, cpu_pkg::op_ori, cpu_pkg::op_lui: begin
        dest    = rt;
        use_imm = 1'b1;
        case (opcode)
          cpu_pkg::op_andi: alu_op = cpu_pkg::alu_and;
          cpu_pkg::op_ori:  alu_op = cpu_pkg::alu_or;
          cpu_pkg::op_lui:  alu_op = cpu_pkg::alu_lui;
          default:          alu_op = cpu_pkg::alu_add;
        endcase
      end
      // nop and anything undefined
      default: writes = 1'b0;
    endcase
    if (dest == '0) begin
      writes = 1'b0;
    end
  end

  //////////////////////////////
  // decode -> execute register
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      ex_valid   <= 1'b0;
      ex_write   <= 1'b0;
      ex_alu_op  <= cpu_pkg::alu_add;
      ex_dest    <= '0;
      ex_rs      <= '0;
      ex_rt      <= '0;
      ex_a       <= '0;
      ex_b       <= '0;
      ex_use_imm <= 1'b0;
      ex_imm     <= '0;
      ex_shamt   <= '0;
    end else begin
      ex_valid   <= instr_valid;
      ex_write   <= instr_valid && writes;
      ex_alu_op  <= alu_op;
      ex_dest    <= dest;
      ex_rs      <= rs;
      ex_rt      <= rt;
      ex_a       <= rd_data_a;
      ex_b       <= rd_data_b;
      ex_use_imm <= use_imm;
      ex_imm     <= imm;
      ex_shamt   <= shamt;
    end
  end

endmodule

// File: hdl/execute_stage.sv
`timescale 1ns/1ns

module execute_stage (
  input  logic               ex_valid,
  input  logic               ex_write,
  input  cpu_pkg::alu_op_t   ex_alu_op,
  input  cpu_pkg::reg_addr_t ex_dest,
  input  cpu_pkg::reg_addr_t ex_rs,
  input  cpu_pkg::reg_addr_t ex_rt,
  input  cpu_pkg::word_t     ex_a,
  input  cpu_pkg::word_t     ex_b,
  input  logic               ex_use_imm,
  input  cpu_pkg::imm_t      ex_imm,
  input  cpu_pkg::shamt_t    ex_shamt,
  input  logic               wb_valid,
  input  cpu_pkg::reg_addr_t wb_addr,
  input  cpu_pkg::word_t     wb_data,
  output logic               res_valid,
  output logic               res_write,
  output cpu_pkg::reg_addr_t res_dest,
  output cpu_pkg::word_t     res_value
);

  //////////////////////////////
  // operand forwarding
  //////////////////////////////

  cpu_pkg::word_t opnd_a;
  cpu_pkg::word_t opnd_rt;
  cpu_pkg::word_t opnd_b;
  cpu_pkg::word_t imm_ext;

  // the instruction ahead sits in write-back while this one executes;
  // its value is newer than what decode read from the register file
  assign opnd_a  = (wb_valid && wb_addr == ex_rs) ? wb_data : ex_a;
  assign opnd_rt = (wb_valid && wb_addr == ex_rt) ? wb_data : ex_b;

  // zero extend
  assign imm_ext = {{(cpu_pkg::word_width - cpu_pkg::imm_width){1'b0}}, ex_imm};
  assign opnd_b  = ex_use_imm ? imm_ext : opnd_rt;

  //////////////////////////////
  // alu
  //////////////////////////////

  cpu_pkg::word_t alu_out;

  always_comb begin
    case (ex_alu_op)
      cpu_pkg::alu_add: alu_out = opnd_a + opnd_b;
      cpu_pkg::alu_sub: alu_out = opnd_a - opnd_b;
      cpu_pkg::alu_and: alu_out = opnd_a & opnd_b;
      cpu_pkg::alu_or:  alu_out = opnd_a | opnd_b;
      cpu_pkg::alu_xor: alu_out = opnd_a ^ opnd_b;
      // signed compare
      cpu_pkg::alu_slt: begin
        alu_out = cpu_pkg::word_t'($signed(opnd_a) < $signed(opnd_b));
      end
      // shifts act on rt, not rs
      cpu_pkg::alu_sll: alu_out = opnd_b << ex_shamt;
      cpu_pkg::alu_srl: alu_out = opnd_b >> ex_shamt;
      // immediate into the upper half
      cpu_pkg::alu_lui: alu_out = opnd_b << cpu_pkg::imm_width;
      default:          alu_out = '0;
    endcase
  end

  assign res_valid = ex_valid;
  assign res_write = ex_write;
  assign res_dest  = ex_dest;
  assign res_value = alu_out;

  // decode only ever emits listed alu ops
  always_comb begin
    if (ex_valid) begin
      a_known_alu_op: assert (ex_alu_op inside {
        cpu_pkg::alu_add, cpu_pkg::alu_sub, cpu_pkg::alu_and,
        cpu_pkg::alu_or, cpu_pkg::alu_xor, cpu_pkg::alu_slt,
        cpu_pkg::alu_sll, cpu_pkg::alu_srl, cpu_pkg::alu_lui});
    end
  end

endmodule

// File: hdl/result_stage.sv
`timescale 1ns/1ns

module result_stage #(
  parameter int count_width = 16
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   res_valid,
  input  logic                   res_write,
  input  cpu_pkg::reg_addr_t     res_dest,
  input  cpu_pkg::word_t         res_value,
  output logic                   wb_valid,
  output cpu_pkg::reg_addr_t     wb_addr,
  output cpu_pkg::word_t         wb_data,
  output logic [count_width-1:0] retire_count
);

  //////////////////////////////
  // control
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_valid     <= 1'b0;
      retire_count <= '0;
    end else begin
      wb_valid <= res_valid && res_write;
      // nops and r0 writes still retire
      if (res_valid) begin
        retire_count <= retire_count + 1'b1;
      end
    end
  end

  // payload
  always_ff @(posedge clk) begin
    wb_addr <= res_dest;
    wb_data <= res_value;
  end

  // nothing may come out of a freshly reset pipe
  a_wb_quiet_after_rst: assert property (@(posedge clk) rst |=> !wb_valid);

endmodule

// File: hdl/processor.sv
`timescale 1ns/1ns

module processor #(
  parameter int count_width = 16
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   instr_valid,
  input  cpu_pkg::instr_t        instr,
  output logic                   wb_valid,
  output cpu_pkg::reg_addr_t     wb_addr,
  output cpu_pkg::word_t         wb_data,
  output logic [count_width-1:0] retire_count
);

  // register file read side
  cpu_pkg::reg_addr_t rd_addr_a;
  cpu_pkg::reg_addr_t rd_addr_b;
  cpu_pkg::word_t     rd_data_a;
  cpu_pkg::word_t     rd_data_b;

  // decode -> execute
  logic               ex_valid;
  logic               ex_write;
  cpu_pkg::alu_op_t   ex_alu_op;
  cpu_pkg::reg_addr_t ex_dest;
  cpu_pkg::reg_addr_t ex_rs;
  cpu_pkg::reg_addr_t ex_rt;
  cpu_pkg::word_t     ex_a;
  cpu_pkg::word_t     ex_b;
  logic               ex_use_imm;
  cpu_pkg::imm_t      ex_imm;
  cpu_pkg::shamt_t    ex_shamt;

  // execute -> result
  logic               res_valid;
  logic               res_write;
  cpu_pkg::reg_addr_t res_dest;
  cpu_pkg::word_t     res_value;

  //////////////////////////////
  // stages
  //////////////////////////////

  decode_stage u_decode (
    .clk         (clk),
    .rst         (rst),
    .instr_valid (instr_valid),
    .instr       (instr),
    .rd_data_a   (rd_data_a),
    .rd_data_b   (rd_data_b),
    .rd_addr_a   (rd_addr_a),
    .rd_addr_b   (rd_addr_b),
    .ex_valid    (ex_valid),
    .ex_write    (ex_write),
    .ex_alu_op   (ex_alu_op),
    .ex_dest     (ex_dest),
    .ex_rs       (ex_rs),
    .ex_rt       (ex_rt),
    .ex_a        (ex_a),
    .ex_b        (ex_b),
    .ex_use_imm  (ex_use_imm),
    .ex_imm      (ex_imm),
    .ex_shamt    (ex_shamt)
  );

  // written from the write-back ports
  register_file u_regs (
    .clk       (clk),
    .rst       (rst),
    .rd_addr_a (rd_addr_a),
    .rd_addr_b (rd_addr_b),
    .rd_data_a (rd_data_a),
    .rd_data_b (rd_data_b),
    .wr_en     (wb_valid),
    .wr_addr   (wb_addr),
    .wr_data   (wb_data)
  );

  execute_stage u_execute (
    .ex_valid   (ex_valid),
    .ex_write   (ex_write),
    .ex_alu_op  (ex_alu_op),
    .ex_dest    (ex_dest),
    .ex_rs      (ex_rs),
    .ex_rt      (ex_rt),
    .ex_a       (ex_a),
    .ex_b       (ex_b),
    .ex_use_imm (ex_use_imm),
    .ex_imm     (ex_imm),
    .ex_shamt   (ex_shamt),
    .wb_valid   (wb_valid),
    .wb_addr    (wb_addr),
    .wb_data    (wb_data),
    .res_valid  (res_valid),
    .res_write  (res_write),
    .res_dest   (res_dest),
    .res_value  (res_value)
  );

  result_stage #(
    .count_width (count_width)
  ) u_result (
    .clk          (clk),
    .rst          (rst),
    .res_valid    (res_valid),
    .res_write    (res_write),
    .res_dest     (res_dest),
    .res_value    (res_value),
    .wb_valid     (wb_valid),
    .wb_addr      (wb_addr),
    .wb_data      (wb_data),
    .retire_count (retire_count)
  );

endmodule

// File: verification/processor_checker.sv
`timescale 1ns/1ns

module processor_checker #(
  parameter int count_width = 16
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   instr_valid,
  input  cpu_pkg::instr_t        instr,
  input  logic                   wb_valid,
  input  cpu_pkg::reg_addr_t     wb_addr,
  input  cpu_pkg::word_t         wb_data,
  input  logic [count_width-1:0] retire_count,
  output logic                   failed
);

  typedef struct packed {
    logic               valid;
    logic               write;
    cpu_pkg::reg_addr_t dest;
    cpu_pkg::word_t     data;
  } wb_entry_t;

  cpu_pkg::word_t         model [cpu_pkg::num_regs];
  wb_entry_t              pending [$];
  logic                   exp_valid;
  cpu_pkg::reg_addr_t     exp_addr;
  cpu_pkg::word_t         exp_data;
  logic [count_width-1:0] exp_count;
  bit                     error_seen = 1'b0;

  assign failed = error_seen;

  // architectural effect of one instruction on the model
  function automatic wb_entry_t predict(input logic valid, input cpu_pkg::instr_t word);
    wb_entry_t       e;
    logic [5:0]      op;
    cpu_pkg::word_t  a;
    cpu_pkg::word_t  b;
    cpu_pkg::word_t  imm;
    cpu_pkg::shamt_t sh;
    op      = word[cpu_pkg::opcode_msb:cpu_pkg::opcode_lsb];
    a       = model[word[cpu_pkg::rs_msb:cpu_pkg::rs_lsb]];
    b       = model[word[cpu_pkg::rt_msb:cpu_pkg::rt_lsb]];
    imm     = {16'h0000, word[cpu_pkg::imm_msb:cpu_pkg::imm_lsb]};
    sh      = word[cpu_pkg::shamt_msb:cpu_pkg::shamt_lsb];
    e.valid = valid;
    e.write = valid;
    e.dest  = word[cpu_pkg::rd_msb:cpu_pkg::rd_lsb];
    e.data  = '0;
    case (op)
      cpu_pkg::op_add:  e.data = a + b;
      cpu_pkg::op_sub:  e.data = a - b;
      cpu_pkg::op_and:  e.data = a & b;
      cpu_pkg::op_or:   e.data = a | b;
      cpu_pkg::op_xor:  e.data = a ^ b;
      cpu_pkg::op_slt:  e.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      cpu_pkg::op_sll:  e.data = b << sh;
      cpu_pkg::op_srl:  e.data = b >> sh;
      cpu_pkg::op_addi: e.data = a + imm;
      cpu_pkg::op_andi: e.data = a & imm;
      cpu_pkg::op_ori:  e.data = a | imm;
      cpu_pkg::op_lui:  e.data = imm << 16;
      default:          e.write = 1'b0;
    endcase
    // immediate forms target rt
    if (op inside {cpu_pkg::op_addi, cpu_pkg::op_andi, cpu_pkg::op_ori, cpu_pkg::op_lui}) begin
      e.dest = word[cpu_pkg::rt_msb:cpu_pkg::rt_lsb];
    end
    if (e.dest == '0) begin
      e.write = 1'b0;
    end
    return e;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
    $display("FAILED at %0t ns: %s = 0x%08h, expected 0x%08h", $time, name, got, expected);
    error_seen = 1'b1;
  endtask

  //////////////////////////////
  // model and expected write-back
  //////////////////////////////

  always @(posedge clk) begin
    wb_entry_t entry;
    wb_entry_t due;
    if (rst) begin
      foreach (model[i]) begin
        model[i] = '0;
      end
      pending.delete();
      exp_valid <= 1'b0;
      exp_addr  <= '0;
      exp_data  <= '0;
      exp_count <= '0;
    end else begin
      entry = predict(instr_valid, instr);
      if (entry.write) begin
        model[entry.dest] = entry.data;
      end
      pending.push_back(entry);
      // due two edges after acceptance
      if (pending.size() > 1) begin
        due = pending.pop_front();
        exp_valid <= due.write;
        exp_addr  <= due.dest;
        exp_data  <= due.data;
        exp_count <= exp_count + count_width'(due.valid);
      end
    end
  end

  //////////////////////////////
  // port checks
  //////////////////////////////

  a_wb_valid: assert property (@(posedge clk) disable iff (rst) wb_valid == exp_valid)
    else report_mismatch("wb_valid", 32'($sampled(wb_valid)), 32'($sampled(exp_valid)));

  a_wb_addr: assert property (@(posedge clk) disable iff (rst) exp_valid |-> wb_addr == exp_addr)
    else report_mismatch("wb_addr", 32'($sampled(wb_addr)), 32'($sampled(exp_addr)));

  a_wb_data: assert property (@(posedge clk) disable iff (rst) exp_valid |-> wb_data == exp_data)
    else report_mismatch("wb_data", $sampled(wb_data), $sampled(exp_data));

  a_retire: assert property (@(posedge clk) disable iff (rst) retire_count == exp_count)
    else report_mismatch("retire_count", 32'($sampled(retire_count)), 32'($sampled(exp_count)));

endmodule

// File: verification/processor_tb.sv
`timescale 1ns/1ns

module processor_tb;

  localparam int  count_width  = 16;
  localparam int  num_directed = 24;
  localparam int  num_random   = 400;
  localparam time clk_period   = 40;
  // each random instruction may bring one idle slot
  localparam time time_limit   = (num_directed + 2 * num_random + 50) * clk_period;

  logic                   clk;
  logic                   rst;
  logic                   instr_valid;
  cpu_pkg::instr_t        instr;
  logic                   wb_valid;
  cpu_pkg::reg_addr_t     wb_addr;
  cpu_pkg::word_t         wb_data;
  logic [count_width-1:0] retire_count;
  logic                   failed;
  integer                 seed;
  int                     accepted;

  processor #(.count_width (count_width)) DUT (.*);

  processor_checker #(.count_width (count_width)) u_checker (.*);

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  function automatic cpu_pkg::instr_t encode_r(input cpu_pkg::opcode_t op,
      input cpu_pkg::reg_addr_t rs, input cpu_pkg::reg_addr_t rt,
      input cpu_pkg::reg_addr_t rd, input cpu_pkg::shamt_t sh);
    return {op, rs, rt, rd, sh, 6'b000000};
  endfunction

  function automatic cpu_pkg::instr_t encode_i(input cpu_pkg::opcode_t op,
      input cpu_pkg::reg_addr_t rs, input cpu_pkg::reg_addr_t rt, input cpu_pkg::imm_t imm);
    return {op, rs, rt, imm};
  endfunction

  // called on a falling edge, returns on the next one
  task automatic issue(input cpu_pkg::instr_t word);
    instr_valid = 1'b1;
    instr       = word;
    accepted++;
    @(negedge clk);
  endtask

  task automatic idle();
    instr_valid = 1'b0;
    instr       = $random(seed);
    @(negedge clk);
  endtask

  //////////////////////////////
  // stimulus
  //////////////////////////////

  initial begin
    cpu_pkg::instr_t word;
    logic [31:0]     rnd;
    seed        = 32'h8be8;
    accepted    = 0;
    rst         = 1'b1;
    instr_valid = 1'b0;
    instr       = '0;
    repeat (10) @(negedge clk);
    rst = 1'b0;
    idle();
    idle();
    // add chain, forwarding then write-through
    issue(encode_i(cpu_pkg::op_addi, 5'd0, 5'd1, 16'h0005));
    issue(encode_i(cpu_pkg::op_addi, 5'd1, 5'd2, 16'h0003));
    issue(encode_r(cpu_pkg::op_add, 5'd2, 5'd1, 5'd3, 5'd0));
    idle();
    issue(encode_r(cpu_pkg::op_add, 5'd3, 5'd3, 5'd4, 5'd0));
    // r5 goes negative
    issue(encode_i(cpu_pkg::op_lui, 5'd0, 5'd5, 16'h8000));
    issue(encode_r(cpu_pkg::op_slt, 5'd5, 5'd1, 5'd6, 5'd0));
    issue(encode_r(cpu_pkg::op_slt, 5'd1, 5'd5, 5'd7, 5'd0));
    issue(encode_i(cpu_pkg::op_andi, 5'd5, 5'd2, 16'hffff));
    issue(encode_i(cpu_pkg::op_ori, 5'd5, 5'd3, 16'h8001));
    issue(encode_r(cpu_pkg::op_sll, 5'd0, 5'd1, 5'd6, 5'd4));
    issue(encode_r(cpu_pkg::op_srl, 5'd0, 5'd5, 5'd7, 5'd31));
    issue(encode_r(cpu_pkg::op_sub, 5'd1, 5'd2, 5'd4, 5'd0));
    issue(encode_r(cpu_pkg::op_xor, 5'd3, 5'd4, 5'd4, 5'd0));
    issue(encode_r(cpu_pkg::op_or, 5'd4, 5'd6, 5'd5, 5'd0));
    issue(encode_r(cpu_pkg::op_and, 5'd5, 5'd3, 5'd6, 5'd0));
    // retire without a write
    issue('0);
    issue({6'd63, 26'h3ff_ffff});
    issue(encode_i(cpu_pkg::op_addi, 5'd1, 5'd0, 16'h0007));
    idle();
    repeat (num_random) begin
      rnd = $random(seed);
      if (rnd[15:13] == 3'd0) begin
        idle();
      end
      word = $random(seed);
      // 13 to 15 are undefined
      word[cpu_pkg::opcode_msb:cpu_pkg::opcode_lsb] = {2'b00, rnd[3:0]};
      word[cpu_pkg::rs_msb:cpu_pkg::rs_lsb] = {2'b00, rnd[6:4]};
      word[cpu_pkg::rt_msb:cpu_pkg::rt_lsb] = {2'b00, rnd[9:7]};
      // small rd for r-type, full immediate otherwise
      if (rnd[3:0] < 4'd9) begin
        word[cpu_pkg::rd_msb:cpu_pkg::rd_lsb] = {2'b00, rnd[12:10]};
      end
      issue(word);
    end
    idle();
    while (retire_count != count_width'(accepted)) begin
      @(negedge clk);
    end
    // last write-back still has to be sampled
    repeat (2) @(negedge clk);
    if (failed) begin
      $display("Simulation failed");
      $fatal(1, "checker reported an error");
    end else begin
      $display("Simulation passed");
      $finish;
    end
  end

  initial begin
    wait (failed);
    $display("Simulation failed");
    $fatal(1, "stopped at the first error");
  end

  initial begin
    #(time_limit);
    $display("Timeout: retire_count never caught up with the issued instructions");
    $display("Simulation failed");
    $fatal(1, "watchdog expired");
  end

endmodule

// File: compile.f
hdl/cpu_pkg.sv
hdl/register_file.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/result_stage.sv
hdl/processor.sv
verification/processor_checker.sv
verification/processor_tb.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = processor_tb
FILELIST  = compile.f
OBJ_DIR   = obj_dir
PASS_MSG  = Simulation passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
